/* hdl/ccu_pkg.sv */
package ccu_pkg;

  //////////////////////////////////////////////////
  // Cluster geometry
  //////////////////////////////////////////////////

  localparam int NUM_CORES = 2;
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;                  // One data word per line
  localparam int OFFSET_W  = 2;                   // Byte offset within a line
  localparam int LINE_W    = ADDR_W - OFFSET_W;   // Compared for collisions

  // Memory arbiter sources, direct paths first, then controllers
  localparam int NUM_SRC = 2 * NUM_CORES;
  localparam int SRC_W   = $clog2(NUM_SRC);

  //////////////////////////////////////////////////
  // Coherency controller states
  //////////////////////////////////////////////////

  localparam int              ST_W        = 3;
  localparam logic [ST_W-1:0] ST_IDLE     = 3'd0;
  localparam logic [ST_W-1:0] ST_LOOKUP   = 3'd1;
  localparam logic [ST_W-1:0] ST_SNOOP    = 3'd2;
  localparam logic [ST_W-1:0] ST_SNP_WAIT = 3'd3;
  localparam logic [ST_W-1:0] ST_FETCH    = 3'd4;
  localparam logic [ST_W-1:0] ST_MEM_WAIT = 3'd5;
  localparam logic [ST_W-1:0] ST_RESP     = 3'd6;

  // Read address, seen either flat or split into line and offset
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    struct packed {
      logic [LINE_W-1:0]   line;
      logic [OFFSET_W-1:0] offset;
    } f;
  } ccu_addr_u;

endpackage

/* hdl/ccu_port_demux.sv */
`timescale 1ns/1ps

module ccu_port_demux import ccu_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Core read channel
  input  logic              ar_valid_i,
  input  ccu_addr_u         ar_addr_i,
  input  logic              ar_shareable_i,
  output logic              ar_ready_o,
  output logic              r_valid_o,
  output logic [DATA_W-1:0] r_data_o,
  input  logic              r_ready_i,
  // Shareable path, to the coherency controller
  output logic              sh_valid_o,
  output logic [ADDR_W-1:0] sh_addr_o,
  input  logic              sh_ready_i,
  input  logic              sh_rvalid_i,
  input  logic [DATA_W-1:0] sh_rdata_i,
  output logic              sh_rready_o,
  // Direct path, to the memory arbiter
  output logic              dir_valid_o,
  output logic [ADDR_W-1:0] dir_addr_o,
  input  logic              dir_ready_i,
  input  logic              dir_rvalid_i,
  input  logic [DATA_W-1:0] dir_rdata_i,
  output logic              dir_rready_o
);

  logic pend_q;    // Read accepted, response not yet taken
  logic sh_sel_q;  // Pending read went to the controller

  // Request side, steered by the shareable bit
  assign sh_valid_o  = ar_valid_i & ~pend_q & ar_shareable_i;
  assign dir_valid_o = ar_valid_i & ~pend_q & ~ar_shareable_i;
  assign sh_addr_o   = ar_addr_i.flat;
  assign dir_addr_o  = ar_addr_i.flat;
  assign ar_ready_o  = ~pend_q & (ar_shareable_i ? sh_ready_i : dir_ready_i);

  // Response side comes back from the remembered path only
  assign r_valid_o    = pend_q & (sh_sel_q ? sh_rvalid_i : dir_rvalid_i);
  assign r_data_o     = sh_sel_q ? sh_rdata_i : dir_rdata_i;
  assign sh_rready_o  = pend_q & sh_sel_q & r_ready_i;
  assign dir_rready_o = pend_q & ~sh_sel_q & r_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q   <= 1'b0;
      sh_sel_q <= 1'b0;
    end else if (ar_valid_i && ar_ready_o) begin
      pend_q   <= 1'b1;
      sh_sel_q <= ar_shareable_i;
    end else if (r_valid_o && r_ready_i) begin
      pend_q   <= 1'b0;  // Port free again for the next read
    end
  end

endmodule

/* hdl/ccu_lookup.sv */
`timescale 1ns/1ps

module ccu_lookup import ccu_pkg::*; (
  input  logic [NUM_CORES-1:0]             lk_req_i,
  input  logic [NUM_CORES-1:0][LINE_W-1:0] lk_line_i,
  input  logic [NUM_CORES-1:0]             busy_i,
  input  logic [NUM_CORES-1:0][LINE_W-1:0] busy_line_i,
  output logic [NUM_CORES-1:0]             lk_collide_o
);

  // [i][j] set when controller j blocks controller i
  logic [NUM_CORES-1:0][NUM_CORES-1:0] inflight;  // j already owns the line
  logic [NUM_CORES-1:0][NUM_CORES-1:0] overlap;   // j asks for it in the same cycle

  //////////////////////////////////////////////////
  // Pairwise line compare
  //////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_CORES; i++) begin : gen_req
    for (genvar j = 0; j < NUM_CORES; j++) begin : gen_other
      if (j != i) begin : gen_busy
        assign inflight[i][j] = busy_i[j] && (busy_line_i[j] == lk_line_i[i]);
      end else begin : gen_self
        assign inflight[i][j] = 1'b0;
      end

      // Same-cycle tie goes to the lowest index
      if (j < i) begin : gen_prio
        assign overlap[i][j] = lk_req_i[j] && (lk_line_i[j] == lk_line_i[i]);
      end else begin : gen_noprio
        assign overlap[i][j] = 1'b0;
      end
    end

    assign lk_collide_o[i] = lk_req_i[i] & (|{inflight[i], overlap[i]});
  end

endmodule

/* hdl/ccu_ctrl.sv */
`timescale 1ns/1ps

module ccu_ctrl import ccu_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Shareable read from the port demux
  input  logic              req_valid_i,
  input  ccu_addr_u         req_addr_i,
  output logic              req_ready_o,
  output logic              resp_valid_o,
  output logic [DATA_W-1:0] resp_data_o,
  input  logic              resp_ready_i,
  // Line lookup
  output logic              lk_req_o,
  output logic [LINE_W-1:0] lk_line_o,
  input  logic              lk_collide_i,
  output logic              busy_o,
  output logic [LINE_W-1:0] busy_line_o,
  // Snoop of the other core
  output logic              ac_valid_o,
  output logic [ADDR_W-1:0] ac_addr_o,
  input  logic              ac_ready_i,
  input  logic              cr_valid_i,
  input  logic              cr_hit_i,
  input  logic [DATA_W-1:0] cr_data_i,
  output logic              cr_ready_o,
  // Line fetch through the memory arbiter
  output logic              fetch_valid_o,
  output logic [ADDR_W-1:0] fetch_addr_o,
  input  logic              fetch_ready_i,
  input  logic              fetch_rvalid_i,
  input  logic [DATA_W-1:0] fetch_rdata_i,
  output logic              fetch_rready_o
);

  logic [ST_W-1:0]   state_q;
  logic [ST_W-1:0]   state_d;
  ccu_addr_u         addr_q;  // Address of the read in service
  logic [DATA_W-1:0] data_q;  // Line returned to the core

  //////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (req_valid_i) state_d = ST_LOOKUP;
      end
      ST_LOOKUP: begin
        if (!lk_collide_i) state_d = ST_SNOOP;  // Else retry next cycle
      end
      ST_SNOOP: begin
        if (ac_ready_i) state_d = ST_SNP_WAIT;
      end
      ST_SNP_WAIT: begin
        if (cr_valid_i) state_d = cr_hit_i ? ST_RESP : ST_FETCH;
      end
      ST_FETCH: begin
        if (fetch_ready_i) state_d = ST_MEM_WAIT;
      end
      ST_MEM_WAIT: begin
        if (fetch_rvalid_i) state_d = ST_RESP;
      end
      ST_RESP: begin
        if (resp_ready_i) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Address and data registers
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      addr_q <= req_addr_i;
    end
    if (state_q == ST_SNP_WAIT && cr_valid_i && cr_hit_i) begin
      data_q <= cr_data_i;  // Snoop hit, other core has the line
    end else if (state_q == ST_MEM_WAIT && fetch_rvalid_i) begin
      data_q <= fetch_rdata_i;
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  assign req_ready_o  = (state_q == ST_IDLE);
  assign resp_valid_o = (state_q == ST_RESP);
  assign resp_data_o  = data_q;

  // Line stays locked from a passed lookup until the response is taken
  assign lk_req_o    = (state_q == ST_LOOKUP);
  assign lk_line_o   = addr_q.f.line;
  assign busy_o      = (state_q != ST_IDLE) && (state_q != ST_LOOKUP);
  assign busy_line_o = addr_q.f.line;

  assign ac_valid_o = (state_q == ST_SNOOP);
  assign ac_addr_o  = addr_q.flat;
  assign cr_ready_o = (state_q == ST_SNP_WAIT);

  assign fetch_valid_o  = (state_q == ST_FETCH);
  assign fetch_addr_o   = addr_q.flat;
  assign fetch_rready_o = (state_q == ST_MEM_WAIT);

endmodule

/* hdl/ccu_mem_mux.sv */
`timescale 1ns/1ps

module ccu_mem_mux import ccu_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Read sources, direct paths then controllers
  input  logic [NUM_SRC-1:0]             src_valid_i,
  input  logic [NUM_SRC-1:0][ADDR_W-1:0] src_addr_i,
  output logic [NUM_SRC-1:0]             src_ready_o,
  output logic [NUM_SRC-1:0]             src_rvalid_o,
  output logic [NUM_SRC-1:0][DATA_W-1:0] src_rdata_o,
  input  logic [NUM_SRC-1:0]             src_rready_i,
  // Memory read port
  output logic                           mem_ar_valid_o,
  output logic [ADDR_W-1:0]              mem_ar_addr_o,
  output logic [SRC_W-1:0]               mem_ar_tag_o,
  input  logic                           mem_ar_ready_i,
  input  logic                           mem_r_valid_i,
  input  logic [DATA_W-1:0]              mem_r_data_i,
  input  logic [SRC_W-1:0]               mem_r_tag_i,
  output logic                           mem_r_ready_o
);

  logic             lock_q;   // Granted request waits for memory
  logic [SRC_W-1:0] grant_q;
  logic [SRC_W-1:0] rr_q;     // Highest priority source next
  logic [SRC_W-1:0] arb_sel;
  logic [SRC_W-1:0] cand;
  logic [SRC_W-1:0] sel;

  //////////////////////////////////////////////////
  // Request arbitration
  //////////////////////////////////////////////////

  // Walk from the farthest source back to rr_q, so the nearest valid one wins
  always_comb begin
    arb_sel = rr_q;
    cand    = rr_q;
    for (int k = NUM_SRC - 1; k >= 0; k--) begin
      cand = SRC_W'((int'(rr_q) + k) % NUM_SRC);
      if (src_valid_i[cand]) begin
        arb_sel = cand;
      end
    end
  end

  assign sel            = lock_q ? grant_q : arb_sel;
  assign mem_ar_valid_o = src_valid_i[sel];
  assign mem_ar_addr_o  = src_addr_i[sel];
  assign mem_ar_tag_o   = sel;  // Source index travels as the tag

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q  <= 1'b0;
      grant_q <= '0;
      rr_q    <= '0;
    end else if (mem_ar_valid_o) begin
      if (mem_ar_ready_i) begin
        lock_q <= 1'b0;
        rr_q   <= SRC_W'((int'(sel) + 1) % NUM_SRC);
      end else begin
        lock_q  <= 1'b1;  // Hold the grant under back-pressure
        grant_q <= sel;
      end
    end
  end

  //////////////////////////////////////////////////
  // Response routing by tag
  //////////////////////////////////////////////////

  for (genvar k = 0; k < NUM_SRC; k++) begin : gen_src
    assign src_ready_o[k]  = mem_ar_ready_i & (sel == SRC_W'(k));
    assign src_rvalid_o[k] = mem_r_valid_i & (mem_r_tag_i == SRC_W'(k));
    assign src_rdata_o[k]  = mem_r_data_i;
  end

  assign mem_r_ready_o = src_rready_i[mem_r_tag_i];

endmodule

/* hdl/ccu_top.sv */
`timescale 1ns/1ps

module ccu_top import ccu_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // Core read channels
  input  logic [NUM_CORES-1:0]             ar_valid_i,
  input  logic [NUM_CORES-1:0][ADDR_W-1:0] ar_addr_i,
  input  logic [NUM_CORES-1:0]             ar_shareable_i,
  output logic [NUM_CORES-1:0]             ar_ready_o,
  output logic [NUM_CORES-1:0]             r_valid_o,
  output logic [NUM_CORES-1:0][DATA_W-1:0] r_data_o,
  input  logic [NUM_CORES-1:0]             r_ready_i,
  // Snoop channels
  output logic [NUM_CORES-1:0]             ac_valid_o,
  output logic [NUM_CORES-1:0][ADDR_W-1:0] ac_addr_o,
  input  logic [NUM_CORES-1:0]             ac_ready_i,
  input  logic [NUM_CORES-1:0]             cr_valid_i,
  input  logic [NUM_CORES-1:0]             cr_hit_i,
  input  logic [NUM_CORES-1:0][DATA_W-1:0] cr_data_i,
  output logic [NUM_CORES-1:0]             cr_ready_o,
  // Memory read port
  output logic                             mem_ar_valid_o,
  output logic [ADDR_W-1:0]                mem_ar_addr_o,
  output logic [SRC_W-1:0]                 mem_ar_tag_o,
  input  logic                             mem_ar_ready_i,
  input  logic                             mem_r_valid_i,
  input  logic [DATA_W-1:0]                mem_r_data_i,
  input  logic [SRC_W-1:0]                 mem_r_tag_i,
  output logic                             mem_r_ready_o
);

  // Demux to controller
  logic [NUM_CORES-1:0]             sh_valid;
  logic [NUM_CORES-1:0][ADDR_W-1:0] sh_addr;
  logic [NUM_CORES-1:0]             sh_ready;
  logic [NUM_CORES-1:0]             sh_rvalid;
  logic [NUM_CORES-1:0][DATA_W-1:0] sh_rdata;
  logic [NUM_CORES-1:0]             sh_rready;
  // Arbiter sources
  logic [NUM_SRC-1:0]               src_valid;
  logic [NUM_SRC-1:0][ADDR_W-1:0]   src_addr;
  logic [NUM_SRC-1:0]               src_ready;
  logic [NUM_SRC-1:0]               src_rvalid;
  logic [NUM_SRC-1:0][DATA_W-1:0]   src_rdata;
  logic [NUM_SRC-1:0]               src_rready;
  // Lookup
  logic [NUM_CORES-1:0]             lk_req;
  logic [NUM_CORES-1:0][LINE_W-1:0] lk_line;
  logic [NUM_CORES-1:0]             busy;
  logic [NUM_CORES-1:0][LINE_W-1:0] busy_line;
  logic [NUM_CORES-1:0]             lk_collide;

  for (genvar i = 0; i < NUM_CORES; i++) begin : gen_core
    ccu_port_demux i_demux (
      .clk_i, .rst_n_i,
      .ar_valid_i (ar_valid_i[i]), .ar_addr_i (ar_addr_i[i]),
      .ar_shareable_i (ar_shareable_i[i]), .ar_ready_o (ar_ready_o[i]),
      .r_valid_o (r_valid_o[i]), .r_data_o (r_data_o[i]), .r_ready_i (r_ready_i[i]),
      .sh_valid_o (sh_valid[i]), .sh_addr_o (sh_addr[i]), .sh_ready_i (sh_ready[i]),
      .sh_rvalid_i (sh_rvalid[i]), .sh_rdata_i (sh_rdata[i]), .sh_rready_o (sh_rready[i]),
      .dir_valid_o (src_valid[i]), .dir_addr_o (src_addr[i]), .dir_ready_i (src_ready[i]),
      .dir_rvalid_i (src_rvalid[i]), .dir_rdata_i (src_rdata[i]),
      .dir_rready_o (src_rready[i])
    );

    // Controller i snoops the other core, fetches through source NUM_CORES+i
    ccu_ctrl i_ctrl (
      .clk_i, .rst_n_i,
      .req_valid_i (sh_valid[i]), .req_addr_i (sh_addr[i]), .req_ready_o (sh_ready[i]),
      .resp_valid_o (sh_rvalid[i]), .resp_data_o (sh_rdata[i]), .resp_ready_i (sh_rready[i]),
      .lk_req_o (lk_req[i]), .lk_line_o (lk_line[i]), .lk_collide_i (lk_collide[i]),
      .busy_o (busy[i]), .busy_line_o (busy_line[i]),
      .ac_valid_o (ac_valid_o[NUM_CORES-1-i]), .ac_addr_o (ac_addr_o[NUM_CORES-1-i]),
      .ac_ready_i (ac_ready_i[NUM_CORES-1-i]), .cr_valid_i (cr_valid_i[NUM_CORES-1-i]),
      .cr_hit_i (cr_hit_i[NUM_CORES-1-i]), .cr_data_i (cr_data_i[NUM_CORES-1-i]),
      .cr_ready_o (cr_ready_o[NUM_CORES-1-i]),
      .fetch_valid_o (src_valid[NUM_CORES+i]), .fetch_addr_o (src_addr[NUM_CORES+i]),
      .fetch_ready_i (src_ready[NUM_CORES+i]), .fetch_rvalid_i (src_rvalid[NUM_CORES+i]),
      .fetch_rdata_i (src_rdata[NUM_CORES+i]), .fetch_rready_o (src_rready[NUM_CORES+i])
    );
  end

  ccu_lookup i_lookup (
    .lk_req_i (lk_req), .lk_line_i (lk_line), .busy_i (busy),
    .busy_line_i (busy_line), .lk_collide_o (lk_collide)
  );

  ccu_mem_mux i_mem_mux (
    .clk_i, .rst_n_i,
    .src_valid_i (src_valid), .src_addr_i (src_addr), .src_ready_o (src_ready),
    .src_rvalid_o (src_rvalid), .src_rdata_o (src_rdata), .src_rready_i (src_rready),
    .mem_ar_valid_o, .mem_ar_addr_o, .mem_ar_tag_o, .mem_ar_ready_i,
    .mem_r_valid_i, .mem_r_data_i, .mem_r_tag_i, .mem_r_ready_o
  );

endmodule

/* testbench/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial clk_o = 1'b0;
  always #2 clk_o = ~clk_o;  // 4 ns period

  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* testbench/ccu_asserts.sv */
`timescale 1ns/1ps

module ccu_asserts import ccu_pkg::*; (
  input logic                             clk_i,
  input logic                             rst_n_i,
  input logic [NUM_CORES-1:0]             ar_valid_i,
  input logic [NUM_CORES-1:0]             ar_ready_o,
  input logic [NUM_CORES-1:0][ADDR_W-1:0] ar_addr_i,
  input logic [NUM_CORES-1:0]             ar_shareable_i,
  input logic [NUM_CORES-1:0]             r_valid_o,
  input logic [NUM_CORES-1:0]             r_ready_i,
  input logic [NUM_CORES-1:0][DATA_W-1:0] r_data_o,
  input logic [NUM_CORES-1:0]             ac_valid_o,
  input logic [NUM_CORES-1:0]             ac_ready_i,
  input logic [NUM_CORES-1:0][ADDR_W-1:0] ac_addr_o,
  input logic                             mem_ar_valid_o,
  input logic                             mem_ar_ready_i,
  input logic [ADDR_W-1:0]                mem_ar_addr_o,
  input logic [SRC_W-1:0]                 mem_ar_tag_o
);

  for (genvar c = 0; c < NUM_CORES; c++) begin : gen_core
    ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ar_valid_i[c] && !ar_ready_o[c] |=> ar_valid_i[c] && $stable(ar_addr_i[c])
        && $stable(ar_shareable_i[c]))
      else $error("AR payload changed while waiting on core %0d", c);

    r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      r_valid_o[c] && !r_ready_i[c] |=> r_valid_o[c] && $stable(r_data_o[c]))
      else $error("R response dropped under back-pressure on core %0d", c);

    ac_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ac_valid_o[c] && !ac_ready_i[c] |=> ac_valid_o[c] && $stable(ac_addr_o[c]))
      else $error("Snoop address changed while waiting on core %0d", c);
  end

  mem_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_ar_valid_o && !mem_ar_ready_i |=> mem_ar_valid_o && $stable(mem_ar_addr_o)
      && $stable(mem_ar_tag_o))
    else $error("Memory request changed while waiting");

  // Nothing leaves the DUT while in reset
  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> !(|r_valid_o) && !(|ac_valid_o) && !mem_ar_valid_o)
    else $error("Valid output high during reset");

endmodule

/* testbench/ccu_tb.sv */
`timescale 1ns/1ps

module ccu_tb import ccu_pkg::*; ();

  localparam int          TIMEOUT  = 2000;      // Cycles per wait
  localparam int          NUM_RAND = 40;        // Random reads per core
  localparam logic [31:0] MEM_PAT  = 32'h5a5a_0000;
  localparam logic [31:0] SNP_PAT  = 32'h0000_c3c3;

  logic                             clk_i;
  logic                             rst_n_i;
  logic [NUM_CORES-1:0]             ar_valid_i;
  logic [NUM_CORES-1:0][ADDR_W-1:0] ar_addr_i;
  logic [NUM_CORES-1:0]             ar_shareable_i;
  logic [NUM_CORES-1:0]             ar_ready_o;
  logic [NUM_CORES-1:0]             r_valid_o;
  logic [NUM_CORES-1:0][DATA_W-1:0] r_data_o;
  logic [NUM_CORES-1:0]             r_ready_i;
  logic [NUM_CORES-1:0]             ac_valid_o;
  logic [NUM_CORES-1:0][ADDR_W-1:0] ac_addr_o;
  logic [NUM_CORES-1:0]             ac_ready_i;
  logic [NUM_CORES-1:0]             cr_valid_i;
  logic [NUM_CORES-1:0]             cr_hit_i;
  logic [NUM_CORES-1:0][DATA_W-1:0] cr_data_i;
  logic [NUM_CORES-1:0]             cr_ready_o;
  logic                             mem_ar_valid_o;
  logic [ADDR_W-1:0]                mem_ar_addr_o;
  logic [SRC_W-1:0]                 mem_ar_tag_o;
  logic                             mem_ar_ready_i;
  logic                             mem_r_valid_i;
  logic [DATA_W-1:0]                mem_r_data_i;
  logic [SRC_W-1:0]                 mem_r_tag_i;
  logic                             mem_r_ready_o;

  integer      seed = 32'ha22f9150;
  int          errors;
  int          checks;
  bit          timed_out;
  bit          stress;               // Random back-pressure on all ready inputs
  logic [31:0] exp_q [NUM_CORES][$];
  int          rx_count [NUM_CORES];
  time         r_time [NUM_CORES];   // Last R transfer
  int          ac_count [NUM_CORES];
  logic [31:0] ac_last [NUM_CORES];
  time         ac_rise [NUM_CORES];  // Last cycle a snoop became valid
  logic        ac_prev [NUM_CORES];
  logic [31:0] snp_addr [NUM_CORES];
  bit          snp_pend [NUM_CORES];
  int          snp_wait [NUM_CORES];
  logic [31:0] mem_q_addr [$];
  logic [SRC_W-1:0] mem_q_tag [$];
  logic [31:0] watch_addr;
  int          watch_cnt;
  logic [31:0] cache_tbl [NUM_CORES][3];

  tb_clkgen i_clkgen (.clk_o (clk_i), .rst_n_o (rst_n_i));

  ccu_top DUT (.*);

  bind ccu_top ccu_asserts i_asserts (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .ar_valid_i (ar_valid_i), .ar_ready_o (ar_ready_o), .ar_addr_i (ar_addr_i),
    .ar_shareable_i (ar_shareable_i),
    .r_valid_o (r_valid_o), .r_ready_i (r_ready_i), .r_data_o (r_data_o),
    .ac_valid_o (ac_valid_o), .ac_ready_i (ac_ready_i), .ac_addr_o (ac_addr_o),
    .mem_ar_valid_o (mem_ar_valid_o), .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_addr_o (mem_ar_addr_o), .mem_ar_tag_o (mem_ar_tag_o)
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic int pick_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic bit is_cached(int core, logic [31:0] addr);
    for (int k = 0; k < 3; k++) begin
      if (cache_tbl[core][k][31:2] == addr[31:2]) return 1'b1;  // Line match
    end
    return 1'b0;
  endfunction

  function automatic logic [31:0] expect_data(int core, logic [31:0] addr, logic sh);
    if (sh && is_cached(NUM_CORES - 1 - core, addr)) return addr ^ SNP_PAT;
    return addr ^ MEM_PAT;
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic confirm(bit ok, string what);
    checks++;
    assert (ok) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  // One read from a core that waits for the AR handshake and then the response
  task automatic read_txn(int c, logic [31:0] a, logic sh);
    int t;
    int base;
    if (timed_out) return;
    base = rx_count[c];
    @(posedge clk_i);
    ar_valid_i[c]     <= 1'b1;
    ar_addr_i[c]      <= a;
    ar_shareable_i[c] <= sh;
    exp_q[c].push_back(expect_data(c, a, sh));
    t = 0;
    do begin
      @(posedge clk_i);
      t++;
    end while (!ar_ready_o[c] && t < TIMEOUT);
    ar_valid_i[c] <= 1'b0;
    if (!ar_ready_o[c]) begin
      $display("Timeout waiting for the read address handshake on core %0d", c);
      timed_out = 1'b1;
      errors++;
      return;
    end
    t = 0;
    while (rx_count[c] == base && t < TIMEOUT) begin
      @(posedge clk_i);
      t++;
    end
    if (rx_count[c] == base) begin
      $display("Timeout waiting for the read response on core %0d", c);
      timed_out = 1'b1;
      errors++;
    end
  endtask

  task automatic report_test(int n, string name, int err0);
    $display("Test %0d %s: %s", n, name, (errors == err0) ? "ok" : "errors");
  endtask

  //////////////////////////////////////////////////
  // Response compare
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    for (int c = 0; c < NUM_CORES; c++) begin
      if (rst_n_i && r_valid_o[c] && r_ready_i[c]) begin
        if (exp_q[c].size() == 0) begin
          confirm(1'b0, $sformatf("Response on core %0d without a read", c));
        end else begin
          check_value($sformatf("r_data_o[%0d]", c), r_data_o[c], exp_q[c].pop_front());
        end
        rx_count[c]++;
        r_time[c] = $time;
      end
    end
  end

  // Snoop models and core ready inputs
  always @(posedge clk_i) begin
    for (int c = 0; c < NUM_CORES; c++) begin
      if (ac_valid_o[c] && !ac_prev[c]) ac_rise[c] = $time;
      ac_prev[c] = ac_valid_o[c];
      if (ac_valid_o[c] && ac_ready_i[c]) begin
        snp_pend[c] = 1'b1;
        snp_addr[c] = ac_addr_o[c];
        snp_wait[c] = pick_below(4);
        ac_count[c]++;
        ac_last[c]  = ac_addr_o[c];
      end
      if (cr_valid_i[c] && cr_ready_o[c]) begin
        cr_valid_i[c] <= 1'b0;
      end else if (snp_pend[c] && !cr_valid_i[c]) begin
        if (snp_wait[c] == 0) begin
          cr_valid_i[c] <= 1'b1;
          cr_hit_i[c]   <= is_cached(c, snp_addr[c]);
          cr_data_i[c]  <= snp_addr[c] ^ SNP_PAT;
          snp_pend[c]   = 1'b0;
        end else begin
          snp_wait[c]--;
        end
      end
      ac_ready_i[c] <= stress ? 1'(pick_below(2)) : 1'b1;
      r_ready_i[c]  <= stress ? 1'(pick_below(2)) : 1'b1;
    end
  end

  // Memory model answers any pending request so order is not kept
  always @(posedge clk_i) begin
    int idx;
    if (mem_ar_valid_o && mem_ar_ready_i) begin
      mem_q_addr.push_back(mem_ar_addr_o);
      mem_q_tag.push_back(mem_ar_tag_o);
      if (mem_ar_addr_o == watch_addr) watch_cnt++;
    end
    if (mem_r_valid_i && mem_r_ready_o) begin
      mem_r_valid_i <= 1'b0;
    end else if (!mem_r_valid_i && mem_q_addr.size() > 0 && pick_below(3) == 0) begin
      idx = pick_below(mem_q_addr.size());
      mem_r_valid_i <= 1'b1;
      mem_r_data_i  <= mem_q_addr[idx] ^ MEM_PAT;
      mem_r_tag_i   <= mem_q_tag[idx];   // Tag echoed unchanged
      mem_q_addr.delete(idx);
      mem_q_tag.delete(idx);
    end
    mem_ar_ready_i <= stress ? 1'(pick_below(2)) : 1'b1;
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int t;
    int err0;
    int ac_before;
    ar_valid_i     = '0;
    ar_addr_i      = '0;
    ar_shareable_i = '0;
    r_ready_i      = '1;
    ac_ready_i     = '1;
    cr_valid_i     = '0;
    cr_hit_i       = '0;
    cr_data_i      = '0;
    mem_ar_ready_i = 1'b1;
    mem_r_valid_i  = 1'b0;
    mem_r_data_i   = '0;
    mem_r_tag_i    = '0;
    watch_addr     = '0;
    cache_tbl[0]   = '{32'h1004, 32'h100c, 32'h1014};
    cache_tbl[1]   = '{32'h1008, 32'h100c, 32'h1018};
    t = 0;
    while (!rst_n_i && t < TIMEOUT) begin
      @(posedge clk_i);
      t++;
    end
    if (!rst_n_i) begin
      $display("Timeout waiting for the reset release");
      timed_out = 1'b1;
      errors++;
    end

    err0 = errors;
    ac_before = ac_count[0] + ac_count[1];
    read_txn(1, 32'h3000, 1'b0);
    confirm(ac_count[0] + ac_count[1] == ac_before, "Snoop issued for a non-shareable read");
    report_test(1, "non-shareable read", err0);

    err0 = errors;
    ac_before  = ac_count[1];
    watch_addr = 32'h2000;
    watch_cnt  = 0;
    read_txn(0, 32'h2000, 1'b1);
    confirm(ac_count[1] == ac_before + 1, "Expected exactly one snoop on core 1");
    check_value("ac_addr_o[1]", ac_last[1], 32'h2000);
    confirm(watch_cnt == 1, "Memory did not see the fetch after a snoop miss");
    report_test(2, "shareable miss", err0);

    err0 = errors;
    watch_addr = 32'h1008;
    watch_cnt  = 0;
    read_txn(0, 32'h1008, 1'b1);
    confirm(watch_cnt == 0, "Memory was read although the snoop hit");
    report_test(3, "shareable hit", err0);

    err0 = errors;
    fork
      read_txn(0, 32'h100c, 1'b1);
      read_txn(1, 32'h100c, 1'b1);
    join
    confirm(ac_rise[0] > r_time[0], "Core 1 snoop appeared before core 0 finished its read");
    report_test(4, "same-line collision", err0);

    err0 = errors;
    stress = 1'b1;
    fork
      for (int n = 0; n < NUM_RAND; n++) begin
        read_txn(0, 32'h1000 + 32'(pick_below(8)) * 4, 1'(pick_below(2)));
      end
      for (int n = 0; n < NUM_RAND; n++) begin
        read_txn(1, 32'h1000 + 32'(pick_below(8)) * 4, 1'(pick_below(2)));
      end
    join
    stress = 1'b0;
    report_test(5, "random mixed reads", err0);

    $display("Checks: %0d run, %0d failed", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* flist.f */
hdl/ccu_pkg.sv
hdl/ccu_port_demux.sv
hdl/ccu_lookup.sv
hdl/ccu_ctrl.sv
hdl/ccu_mem_mux.sv
hdl/ccu_top.sv
testbench/tb_clkgen.sv
testbench/ccu_asserts.sv
testbench/ccu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the coherency interconnect testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ccu_tb -f flist.f -o ccu_sim
./obj_dir/ccu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
  exit 0
else
  exit 1
fi
